// File: bench/cart_slot_checker.sv
/*
 * Response checker for the cartridge slot testbench
 * Models the bank registers, queue occupancy and ROM contents, and
 * compares responses, stalls and read latency with the DUT
 */
`default_nettype none

module cart_slot_checker #(
    parameter int DEPTH = 4
) (
    input  logic                       cpu_bus,
    input  logic                       rst_n,
    input  logic [15:0]                addr,
    input  logic [7:0]                 data,
    input  logic                       mreq,
    input  logic                       req,
    input  logic                       rd,
    input  logic                       wr,
    input  logic                       slot,
    input  logic                       wait_req,
    input  cart_pkg::cart_type_t [1:0] slot_type,
    input  logic [1:0][3:0]            slot_blocks,
    input  logic                       rsp_valid,
    input  logic [7:0]                 rsp_data,
    input  logic                       rsp_slot,
    input  logic                       rsp_ready,
    input  logic                       done,
    output int                         error_count
);
    import cart_pkg::*;

    // Block behind 8000h-BFFFh for each slot, -1 when the window is unmapped
    int         upper_block [2];
    // Reads sitting in the queue, and whether the store holds a response
    int         in_queue;
    logic       reg_full;
    int         cyc = 0;
    int         probe_cyc = -1;
    int         checked = 0;
    int         data_errors = 0;
    int         proto_errors = 0;
    logic       reported = 1'b0;
    logic [7:0] exp_data_q [$];
    logic       exp_slot_q [$];

    assign error_count = data_errors + proto_errors;

    // Bank byte carries the block in bits 7..1; values past the count wrap
    // on count-1 and anything still too large leaves the window unmapped
    function automatic int fold_block(input logic [7:0] value, input logic [3:0] blocks);
        int raw;
        int cnt;
        int blk;
        raw = int'(value[7:1]);
        cnt = int'(blocks);
        if (raw < cnt) begin
            blk = raw;
        end else begin
            blk = raw & (cnt - 1);
        end
        if (blk < cnt) begin
            return blk;
        end
        return -1;
    endfunction

    task automatic report_mismatch(input string check, input int expected, input int actual);
        $display("Error %s %s: expected %0h, actual %0h",
                 cart_slot_tb.test_name, check, expected, actual);
    endtask

    // All sampling happens on the rising edge, where the DUT sees the same inputs
    always @(posedge cpu_bus) begin : model
        logic                  wait_m;
        logic                  accept;
        logic                  sel;
        logic                  push_m;
        logic                  pop_m;
        int                    blk;
        logic [ROM_ADDR_W-1:0] idx;
        logic [7:0]            exp_data;
        logic                  exp_slot;
        if (!rst_n) begin
            upper_block[0] = 0;
            upper_block[1] = 0;
            in_queue = 0;
            reg_full = 1'b0;
            probe_cyc = -1;
            exp_data_q.delete();
            exp_slot_q.delete();
        end else begin
            cyc++;
            // The bus stalls exactly when the queue behind the store is full
            wait_m = (in_queue == DEPTH);
            if (wait_req !== wait_m) begin
                report_mismatch("wait_req", int'(wait_m), int'(wait_req));
                proto_errors++;
            end
            if (rsp_valid !== reg_full) begin
                report_mismatch("rsp_valid", int'(reg_full), int'(rsp_valid));
                proto_errors++;
            end
            // A read taken with nothing in flight answers two edges later
            if (cyc == probe_cyc && rsp_valid !== 1'b1) begin
                report_mismatch("latency", 1, int'(rsp_valid));
                proto_errors++;
            end
            if (rsp_valid && rsp_ready) begin
                if (exp_data_q.size() == 0) begin
                    $display("Response %h on slot %0d arrived with no read outstanding",
                             rsp_data, rsp_slot);
                    proto_errors++;
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_slot = exp_slot_q.pop_front();
                    checked++;
                    if (rsp_data !== exp_data) begin
                        report_mismatch("rsp_data", int'(exp_data), int'(rsp_data));
                        data_errors++;
                    end
                    if (rsp_slot !== exp_slot) begin
                        report_mismatch("rsp_slot", int'(exp_slot), int'(rsp_slot));
                        data_errors++;
                    end
                end
            end
            accept = req && mreq && !wait_m;
            sel = (slot_type[slot] == MAPPER_SUPERSWANGI) && mreq &&
                  (addr >= 16'h4000) && (addr < 16'hC000);
            push_m = 1'b0;
            if (accept && sel && wr && addr == SWITCH_ADDR) begin
                upper_block[slot] = fold_block(data, slot_blocks[slot]);
            end
            if (accept && sel && rd) begin
                // Lower window is fixed on block 0
                blk = (addr >= 16'h8000) ? upper_block[slot] : 0;
                if (blk >= 0) begin
                    idx = ROM_ADDR_W'((int'(slot) << (BANK_SEL_W + BANK_OFFSET_W)) +
                                      (blk << BANK_OFFSET_W) + int'(addr[13:0]));
                    if (exp_data_q.size() == 0) begin
                        probe_cyc = cyc + 2;
                    end
                    exp_data_q.push_back(cart_slot_tb.rom_image[idx]);
                    exp_slot_q.push_back(slot);
                    push_m = 1'b1;
                end
            end
            // Store takes the head when its register is free or being emptied
            pop_m = (in_queue > 0) && (!reg_full || rsp_ready);
            if (pop_m) begin
                reg_full = 1'b1;
            end else if (rsp_ready) begin
                reg_full = 1'b0;
            end
            in_queue = in_queue + int'(push_m) - int'(pop_m);
            if (done && !reported) begin
                if (exp_data_q.size() != 0) begin
                    $display("%0d accepted reads never got a response", exp_data_q.size());
                    proto_errors++;
                end
                $display("Checked %0d responses: %0d data errors, %0d protocol errors",
                         checked, data_errors, proto_errors);
                reported = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/cart_slot_tb.sv
/*
 * Testbench for the two-slot cartridge subsystem
 * Loads both ROM images, then runs timed reads, random bus traffic under
 * random response back-pressure, and traffic to a disabled slot
 */
`default_nettype none

module cart_slot_tb;
    import cart_pkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int ROM_SIZE    = 2**ROM_ADDR_W;
    localparam int N_TIMED     = 16;
    localparam int N_RANDOM    = 400;
    localparam int N_NONE      = 150;
    localparam int LOAD_CYCLES = ROM_SIZE + 5;
    localparam int TOTAL_OPS   = N_TIMED + N_RANDOM + N_NONE;
    // Twenty cycles per operation leaves room for long stalls
    localparam int WATCHDOG_CYCLES = LOAD_CYCLES + TOTAL_OPS * 20;

    logic                  cpu_bus = 1'b0;
    logic                  rst_n;
    logic [15:0]           addr;
    logic [7:0]            data;
    logic                  mreq;
    logic                  req;
    logic                  rd;
    logic                  wr;
    logic                  slot;
    logic                  wait_req;
    cart_type_t [1:0]      slot_type;
    logic [1:0][3:0]       slot_blocks;
    logic                  load_we;
    logic [ROM_ADDR_W-1:0] load_addr;
    logic [7:0]            load_data;
    logic                  rsp_valid;
    logic [7:0]            rsp_data;
    logic                  rsp_slot;
    logic                  rsp_ready;

    // Copy of the loaded bytes, the checker reads it as its ROM model
    logic [7:0] rom_image [ROM_SIZE];
    string      test_name = "rom_load";
    integer     seed = 32'h7527;
    logic       ready_random;
    logic       done;
    int         error_count;

    always #50 cpu_bus = ~cpu_bus;

    cart_slot_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_dut (
        .cpu_bus (cpu_bus), .rst_n (rst_n), .addr (addr), .data (data),
        .mreq (mreq), .req (req), .rd (rd), .wr (wr), .slot (slot),
        .wait_req (wait_req), .slot_type (slot_type), .slot_blocks (slot_blocks),
        .load_we (load_we), .load_addr (load_addr), .load_data (load_data),
        .rsp_valid (rsp_valid), .rsp_data (rsp_data), .rsp_slot (rsp_slot),
        .rsp_ready (rsp_ready)
    );

    cart_slot_checker #(
        .DEPTH (QUEUE_DEPTH)
    ) u_checker (
        .cpu_bus (cpu_bus), .rst_n (rst_n), .addr (addr), .data (data),
        .mreq (mreq), .req (req), .rd (rd), .wr (wr), .slot (slot),
        .wait_req (wait_req), .slot_type (slot_type), .slot_blocks (slot_blocks),
        .rsp_valid (rsp_valid), .rsp_data (rsp_data), .rsp_slot (rsp_slot),
        .rsp_ready (rsp_ready), .done (done), .error_count (error_count)
    );

    // Every clock advance goes through here so rsp_ready follows the edge
    task automatic next_cycle();
        logic [31:0] rnd;
        @(posedge cpu_bus);
        if (ready_random) begin
            rnd = $random(seed);
            rsp_ready <= rnd[0];
        end else begin
            rsp_ready <= 1'b1;
        end
    endtask

    // Holds the access until an edge with wait_req low takes it
    task automatic bus_access(input logic s, input logic [15:0] a, input logic [7:0] d,
                              input logic is_wr);
        logic taken;
        taken = 1'b0;
        slot <= s;
        addr <= a;
        data <= d;
        mreq <= 1'b1;
        req  <= 1'b1;
        rd   <= ~is_wr;
        wr   <= is_wr;
        while (!taken) begin
            @(negedge cpu_bus);
            taken = ~wait_req;
            next_cycle();
        end
        req  <= 1'b0;
        mreq <= 1'b0;
        rd   <= 1'b0;
        wr   <= 1'b0;
    endtask

    task automatic await_response();
        @(negedge cpu_bus);
        while (!rsp_valid) begin
            next_cycle();
            @(negedge cpu_bus);
        end
        next_cycle();
    endtask

    // With rsp_ready high a low rsp_valid means the queue has run dry
    task automatic drain();
        ready_random = 1'b0;
        repeat (2) next_cycle();
        @(negedge cpu_bus);
        while (rsp_valid) begin
            next_cycle();
            @(negedge cpu_bus);
        end
        next_cycle();
    endtask

    task automatic load_rom();
        logic [31:0] rnd;
        for (int i = 0; i < ROM_SIZE; i++) begin
            rnd = $random(seed);
            rom_image[ROM_ADDR_W'(i)] = rnd[7:0];
            load_we   <= 1'b1;
            load_addr <= ROM_ADDR_W'(i);
            load_data <= rnd[7:0];
            next_cycle();
        end
        load_we <= 1'b0;
    endtask

    // Mostly window reads, with bank writes, stray writes and out-of-window traffic
    task automatic random_op();
        logic [31:0] r;
        logic [31:0] v;
        logic [15:0] a;
        r = $random(seed);
        v = $random(seed);
        case (r[2:0])
            3'd0, 3'd1: begin
                bus_access(r[3], SWITCH_ADDR, v[7:0], 1'b1);
            end
            3'd6: begin
                a = v[16] ? {2'b01, v[13:0]} : {2'b10, v[13:1], 1'b1};
                bus_access(r[3], a, v[7:0], 1'b1);
            end
            3'd7: begin
                a = {v[15], v[15], v[13:0]};
                bus_access(r[3], a, v[23:16], v[17]);
            end
            default: begin
                a = {v[15], ~v[15], v[13:0]};
                bus_access(r[3], a, 8'h00, 1'b0);
            end
        endcase
        if (r[6:4] == 3'd0) begin
            repeat (int'(r[9:7]) + 1) next_cycle();
        end
    endtask

    initial begin
        logic [31:0] rnd;
        rst_n = 1'b0;
        addr = '0;
        data = '0;
        mreq = 1'b0;
        req = 1'b0;
        rd = 1'b0;
        wr = 1'b0;
        slot = 1'b0;
        slot_type[0] = MAPPER_SUPERSWANGI;
        slot_type[1] = MAPPER_SUPERSWANGI;
        // Six blocks on slot 1 exercise folding on a count that is not a power of two
        slot_blocks[0] = 4'd8;
        slot_blocks[1] = 4'd6;
        load_we = 1'b0;
        load_addr = '0;
        load_data = '0;
        rsp_ready = 1'b0;
        ready_random = 1'b0;
        done = 1'b0;
        repeat (5) next_cycle();
        rst_n <= 1'b1;
        load_rom();

        test_name = "reset_bank_reads";
        for (int i = 0; i < N_TIMED; i++) begin
            rnd = $random(seed);
            bus_access(rnd[16], {rnd[15], ~rnd[15], rnd[13:0]}, 8'h00, 1'b0);
            await_response();
        end

        test_name = "random_traffic";
        ready_random = 1'b1;
        repeat (N_RANDOM) random_op();
        drain();

        test_name = "unmapped_slot";
        slot_type[1] <= MAPPER_NONE;
        ready_random = 1'b1;
        repeat (N_NONE) random_op();
        drain();

        done <= 1'b1;
        next_cycle();
        @(negedge cpu_bus);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 100);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: cart_slot_top.f
src/cart_pkg.sv
src/swangi_mapper.sv
src/read_queue.sv
src/rom_store.sv
src/cart_slot_top.sv
bench/cart_slot_checker.sv
bench/cart_slot_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the cartridge slot testbench with Verilator and runs it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cart_slot_tb -Mdir obj_dir -f cart_slot_top.f

out=$(./obj_dir/Vcart_slot_tb)
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: src/cart_pkg.sv
/*
 * Cartridge slot definitions
 * Mapper type codes, the fixed ROM layout and the ROM address word
 * shared by the bank mapper, the read queue and the ROM store
 */
`default_nettype none

package cart_pkg;

    // Mapper kind fitted in a slot, only Super Swangi is decoded here
    typedef enum logic [2:0] {
        MAPPER_NONE        = 3'd0,
        MAPPER_SUPERSWANGI = 3'd1
    } cart_type_t;

    // Offset bits inside one 16 KB block
    localparam int BANK_OFFSET_W = 14;

    // Block number bits kept per slot, 8 blocks of 16 KB at most
    localparam int BANK_SEL_W = 3;

    // Slot bit on top of bank and offset
    localparam int ROM_ADDR_W = 1 + BANK_SEL_W + BANK_OFFSET_W;

    // Bank-switch register of the mapper
    localparam logic [15:0] SWITCH_ADDR = 16'h8000;

    // Decoded view of a ROM address as the mapper assembles it
    typedef struct packed {
        logic                     slot;
        logic [BANK_SEL_W-1:0]    bank;
        logic [BANK_OFFSET_W-1:0] offset;
    } rom_fields_t;

    // One ROM address word, built from fields and indexed as a flat array
    // position by the store
    typedef union packed {
        rom_fields_t           fields;
        logic [ROM_ADDR_W-1:0] flat;
    } rom_addr_u;

endpackage

`default_nettype wire

// File: src/cart_slot_top.sv
/*
 * Two-slot cartridge subsystem
 * Bank mapper feeding a read queue that drains into the ROM store
 */
`default_nettype none

module cart_slot_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              cpu_bus,
    input  logic                              rst_n,

    // CPU memory bus
    input  logic [15:0]                       addr,
    input  logic [7:0]                        data,
    input  logic                              mreq,
    input  logic                              req,
    input  logic                              rd,
    input  logic                              wr,
    input  logic                              slot,
    output logic                              wait_req,

    // Static slot configuration
    input  cart_pkg::cart_type_t [1:0]        slot_type,
    input  logic [1:0][3:0]                   slot_blocks,

    // ROM loader
    input  logic                              load_we,
    input  logic [cart_pkg::ROM_ADDR_W-1:0]   load_addr,
    input  logic [7:0]                        load_data,

    // Read response, returned in request order
    output logic                              rsp_valid,
    output logic [7:0]                        rsp_data,
    output logic                              rsp_slot,
    input  logic                              rsp_ready
);
    import cart_pkg::*;

    // Mapper to queue
    logic      push;
    rom_addr_u push_addr;
    logic      full;

    // Queue to store
    logic      q_valid;
    rom_addr_u q_addr;
    logic      pop;

    swangi_mapper u_mapper (
        .cpu_bus     (cpu_bus),
        .rst_n       (rst_n),
        .addr        (addr),
        .data        (data),
        .mreq        (mreq),
        .req         (req),
        .rd          (rd),
        .wr          (wr),
        .slot        (slot),
        .slot_type   (slot_type),
        .slot_blocks (slot_blocks),
        .full        (full),
        .push        (push),
        .push_addr   (push_addr),
        .wait_req    (wait_req)
    );

    // Queue depth sets how many reads may be pending before the bus stalls
    read_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .push      (push),
        .push_addr (push_addr),
        .pop       (pop),
        .full      (full),
        .q_valid   (q_valid),
        .q_addr    (q_addr)
    );

    rom_store u_store (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .load_we   (load_we),
        .load_addr (load_addr),
        .load_data (load_data),
        .q_valid   (q_valid),
        .q_addr    (q_addr),
        .rsp_ready (rsp_ready),
        .pop       (pop),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .rsp_slot  (rsp_slot)
    );

endmodule

`default_nettype wire

// File: src/read_queue.sv
/*
 * Read address FIFO
 * Holds translated ROM addresses between the mapper and the ROM store
 * and signals full so the CPU bus stalls
 */
`default_nettype none

module read_queue #(
    parameter int DEPTH = 4
) (
    input  logic                cpu_bus,
    input  logic                rst_n,
    input  logic                push,
    input  cart_pkg::rom_addr_u push_addr,
    input  logic                pop,
    output logic                full,
    output logic                q_valid,
    output cart_pkg::rom_addr_u q_addr
);
    import cart_pkg::*;

    // A single entry queue still needs one pointer bit
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rom_addr_u        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign full    = (count == CNT_W'(DEPTH));
    assign q_valid = (count != '0);

    // Head entry goes straight to the store
    assign q_addr = mem[rd_ptr];

    // Storage itself carries no reset, the count says what is valid
    always_ff @(posedge cpu_bus) begin
        if (push) begin
            mem[wr_ptr] <= push_addr;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH, which need not be a power of two
            if (push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Simultaneous push and pop leave the occupancy unchanged
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    // Overflow would overwrite the oldest pending read
    a_no_overflow: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        push |-> !full
    );

    // The store may only drain what has been queued
    a_no_underflow: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        pop |-> q_valid
    );

endmodule

`default_nettype wire

// File: src/rom_store.sv
/*
 * Cartridge ROM store
 * One byte array with an image per slot, filled by the loader port and
 * read in queue order into a registered valid/ready response
 */
`default_nettype none

module rom_store (
    input  logic                              cpu_bus,
    input  logic                              rst_n,
    input  logic                              load_we,
    input  logic [cart_pkg::ROM_ADDR_W-1:0]   load_addr,
    input  logic [7:0]                        load_data,
    input  logic                              q_valid,
    input  cart_pkg::rom_addr_u               q_addr,
    input  logic                              rsp_ready,
    output logic                              pop,
    output logic                              rsp_valid,
    output logic [7:0]                        rsp_data,
    output logic                              rsp_slot
);
    import cart_pkg::*;

    // Slot 0 image fills the lower half and slot 1 the upper half
    logic [7:0] rom [2**ROM_ADDR_W];

    // Take the next read when the response register is free or empties
    // on this very edge
    assign pop = q_valid && (!rsp_valid || rsp_ready);

    // Loader writes one byte per cycle before any traffic starts
    always_ff @(posedge cpu_bus) begin
        if (load_we) begin
            rom[load_addr] <= load_data;
        end
    end

    // Response payload only changes on a pop, so it holds under
    // back-pressure
    always_ff @(posedge cpu_bus) begin
        if (pop) begin
            rsp_data <= rom[q_addr.flat];
            rsp_slot <= q_addr.fields.slot;
        end
    end

    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (pop) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            // Response taken and nothing queued behind it
            rsp_valid <= 1'b0;
        end
    end

    // Loading while reads are in flight would mix old and new images
    a_load_idle: assert property (
        @(posedge cpu_bus) disable iff (!rst_n)
        load_we |-> (!q_valid && !rsp_valid)
    );

endmodule

`default_nettype wire

// File: src/swangi_mapper.sv
/*
 * Super Swangi bank mapper for two cartridge slots
 * Decodes CPU memory accesses, keeps the per-slot bank registers and
 * turns mapped reads into ROM addresses for the read queue
 */
`default_nettype none

module swangi_mapper (
    input  logic                       cpu_bus,
    input  logic                       rst_n,
    input  logic [15:0]                addr,
    input  logic [7:0]                 data,
    input  logic                       mreq,
    input  logic                       req,
    input  logic                       rd,
    input  logic                       wr,
    input  logic                       slot,
    input  cart_pkg::cart_type_t [1:0] slot_type,
    input  logic [1:0][3:0]            slot_blocks,
    input  logic                       full,
    output logic                       push,
    output cart_pkg::rom_addr_u        push_addr,
    output logic                       wait_req
);
    import cart_pkg::*;

    // Bank entries per slot, bit 8 flags an unmapped entry and bits 7..0
    // hold the block number
    logic [8:0] bank [2][2];

    logic       sel;
    logic       accept;
    logic       bank_we;
    logic [7:0] raw_block;
    logic [7:0] nr_blocks;
    logic [7:0] block_mask;
    logic [7:0] folded;
    logic [8:0] new_entry;
    logic [8:0] rd_entry;

    // Only 4000h-BFFFh belongs to the cartridge, both ends are left alone
    assign sel = (slot_type[slot] == MAPPER_SUPERSWANGI) && mreq && (addr[15] ^ addr[14]);

    // A full queue stalls the CPU for writes as well as reads
    assign wait_req = full;

    // Bus cycle that the mapper actually takes this edge
    assign accept = req && mreq && !wait_req;

    assign bank_we = accept && sel && wr && (addr == SWITCH_ADDR);

    // The written byte carries the block number in bits 7..1
    assign raw_block  = {1'b0, data[7:1]};
    assign nr_blocks  = {4'b0000, slot_blocks[slot]};
    assign block_mask = nr_blocks - 8'd1;

    // Out of range numbers wrap on the block count mask
    assign folded = (raw_block < nr_blocks) ? raw_block : (raw_block & block_mask);

    // Whatever still falls past the ROM end reads as open bus
    assign new_entry = (folded < nr_blocks) ? {1'b0, folded} : {1'b1, 8'h00};

    // Bank write lands on the accepting edge, the next read sees it
    always_ff @(posedge cpu_bus) begin
        if (!rst_n) begin
            bank[0][0] <= '0;
            bank[0][1] <= '0;
            bank[1][0] <= '0;
            bank[1][1] <= '0;
        end else if (bank_we) begin
            // Entry 0 stays on block 0, only the upper window switches
            bank[slot][1] <= new_entry;
        end
    end

    // Address bit 15 picks 4000h-7FFFh (entry 0) or 8000h-BFFFh (entry 1)
    assign rd_entry = bank[slot][addr[15]];

    // Unmapped windows return nothing and do not occupy the queue
    assign push = accept && sel && rd && !rd_entry[8];

    always_comb begin
        push_addr.fields.slot   = slot;
        push_addr.fields.bank   = rd_entry[BANK_SEL_W-1:0];
        push_addr.fields.offset = addr[BANK_OFFSET_W-1:0];
    end

    // The slot configuration must keep every stored block inside the
    // 3-bit bank field of the ROM address
    for (genvar s = 0; s < 2; s++) begin : g_bank_chk
        a_block_range: assert property (
            @(posedge cpu_bus) disable iff (!rst_n)
            !bank[s][1][8] |-> (bank[s][1][7:0] < 8'(1 << BANK_SEL_W))
        );
    end

endmodule

`default_nettype wire
